/* hw/CoreTypes.sv */
package CoreTypes;

    // Native word of the core, used for both load and store data
    typedef logic [31:0] Data;

    // Byte address as issued by the load/store unit
    typedef logic [31:0] DataAddr;

    typedef enum logic [1:0]
    {
        DataSize_8  = 2'b00, // Byte
        DataSize_16 = 2'b01, // Halfword
        DataSize_32 = 2'b10  // Word
    } DataSize;

    // One bit per byte lane, bit 3 is lane offset 0 (bits 31..24)
    typedef logic [3:0] ByteMask;

endpackage

/* hw/MemMap.sv */
package MemMap;

    localparam int WordOffsetBits = 2;                 // Byte offset bits inside a word
    localparam int ShiftBits = WordOffsetBits + 3;     // Width of a bit shift across a word
    localparam int DefaultMemWords = 256;

    // Lanes are big-endian, so offset 0 sits in the most significant lane
    function automatic logic [WordOffsetBits-1:0] laneIndex(
        input logic [WordOffsetBits-1:0] offset);
        return ~offset;
    endfunction

    // Bit position of the least significant bit of the byte at this offset
    function automatic logic [ShiftBits-1:0] laneShift(
        input logic [WordOffsetBits-1:0] offset);
        return {laneIndex(offset), 3'b000};
    endfunction

endpackage

/* hw/DataMemoryBus.sv */
`timescale 1ns/10ps

interface DataMemoryBus;

    CoreTypes::DataAddr addr;
    CoreTypes::Data     wrData;    // Already steered into its byte lanes
    CoreTypes::ByteMask wrMask;
    logic               wrEnable;
    logic               rdEnable;
    CoreTypes::Data     rdData;    // Whole word, 0 when the read is not performed
    logic               rangeError;

    modport master
    (
        output addr,
        output wrData,
        output wrMask,
        output wrEnable,
        output rdEnable,
        input  rdData,
        input  rangeError
    );

    modport slave
    (
        input  addr,
        input  wrData,
        input  wrMask,
        input  wrEnable,
        input  rdEnable,
        output rdData,
        output rangeError
    );

endinterface

/* hw/DataMemoryAdapter.sv */
`timescale 1ns/10ps

module DataMemoryAdapter
(
    input  CoreTypes::DataAddr i_addr,
    input  CoreTypes::DataSize i_size,
    input  logic               i_unsigned,
    input  logic               i_wrEnable,
    input  CoreTypes::Data     i_wrData,
    input  logic               i_rdEnable,
    output CoreTypes::Data     o_rdData,
    output logic               o_alignError,
    DataMemoryBus.master       bus
);

    logic [MemMap::WordOffsetBits-1:0] offset;
    logic [MemMap::WordOffsetBits-1:0] lowOffset;
    logic [MemMap::ShiftBits-1:0]      shift;
    logic                              aligned;
    logic                              anyEnable;
    CoreTypes::Data                    storeData;
    CoreTypes::ByteMask                baseMask;
    CoreTypes::Data                    rdLane;
    CoreTypes::Data                    extended;

    assign offset    = i_addr[MemMap::WordOffsetBits-1:0];
    assign anyEnable = i_wrEnable | i_rdEnable;

    // The least significant byte of an access sits at its highest offset,
    // so that byte decides the lane shift for data and mask alike
    always_comb
    begin
        aligned   = 1'b0;
        lowOffset = offset;
        storeData = '0;
        baseMask  = '0;

        case (i_size)
            CoreTypes::DataSize_8:
            begin
                aligned   = 1'b1;
                lowOffset = offset;
                storeData = {24'b0, i_wrData[7:0]};
                baseMask  = 4'b0001;
            end

            CoreTypes::DataSize_16:
            begin
                aligned   = ~offset[0];
                lowOffset = offset | 2'b01;
                storeData = {16'b0, i_wrData[15:0]};
                baseMask  = 4'b0011;
            end

            CoreTypes::DataSize_32:
            begin
                aligned   = (offset == '0);
                lowOffset = '1;
                storeData = i_wrData;
                baseMask  = 4'b1111;
            end

            default:
            begin
                aligned = 1'b0; // Unused size code is never a legal access
            end
        endcase
    end

    assign shift = MemMap::laneShift(lowOffset);

    assign bus.addr     = i_addr;
    assign bus.wrData   = storeData << shift;
    assign bus.wrMask   = baseMask << MemMap::laneIndex(lowOffset);
    assign bus.wrEnable = i_wrEnable & aligned;
    assign bus.rdEnable = i_rdEnable & ~i_wrEnable & aligned; // Both enables count as a write

    assign o_alignError = anyEnable & ~aligned;

    assign rdLane = bus.rdData >> shift;

    always_comb
    begin
        case (i_size)
            CoreTypes::DataSize_8:
            begin
                if (i_unsigned)
                    extended = {24'b0, rdLane[7:0]};
                else
                    extended = {{24{rdLane[7]}}, rdLane[7:0]};
            end

            CoreTypes::DataSize_16:
            begin
                if (i_unsigned)
                    extended = {16'b0, rdLane[15:0]};
                else
                    extended = {{16{rdLane[15]}}, rdLane[15:0]};
            end

            default:
            begin
                extended = rdLane; // Word loads need no extension
            end
        endcase
    end

    assign o_rdData = bus.rdEnable ? extended : '0;

endmodule

/* hw/DataMemory.sv */
`timescale 1ns/10ps

module DataMemory
#(
    parameter int MemWords = MemMap::DefaultMemWords
)
(
    input  logic        i_clk,
    input  logic        i_arstN,
    DataMemoryBus.slave bus
);

    localparam int IndexBits = $clog2(MemWords);
    localparam int AddrBits = $bits(CoreTypes::DataAddr);

    CoreTypes::Data       mem [MemWords];
    logic [IndexBits-1:0] wordIndex;
    logic                 inRange;

    assign wordIndex = bus.addr[MemMap::WordOffsetBits +: IndexBits];

    // Any address bit above the array index means the word lies past the end
    assign inRange = (bus.addr[AddrBits-1:MemMap::WordOffsetBits+IndexBits] == '0);

    assign bus.rangeError = (bus.wrEnable | bus.rdEnable) & ~inRange;
    assign bus.rdData     = (bus.rdEnable && inRange) ? mem[wordIndex] : '0;

    always_ff @(posedge i_clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            for (int word = 0; word < MemWords; word++)
            begin
                mem[word] <= '0;
            end
        end
        else if (bus.wrEnable && inRange)
        begin
            for (int lane = 0; lane < $bits(CoreTypes::ByteMask); lane++)
            begin
                if (bus.wrMask[lane])
                    mem[wordIndex][lane*8 +: 8] <= bus.wrData[lane*8 +: 8];
            end
        end
    end

endmodule

/* hw/DataMemorySystem.sv */
`timescale 1ns/10ps

module DataMemorySystem
#(
    parameter int MemWords = MemMap::DefaultMemWords
)
(
    input  logic               i_clk,
    input  logic               i_arstN,
    input  CoreTypes::DataAddr i_addr,
    input  CoreTypes::DataSize i_size,
    input  logic               i_unsigned,
    input  logic               i_wrEnable,
    input  CoreTypes::Data     i_wrData,
    input  logic               i_rdEnable,
    output CoreTypes::Data     o_rdData,
    output logic               o_alignError,
    output logic               o_rangeError
);

    DataMemoryBus bus ();

    DataMemoryAdapter adapter
    (
        .i_addr       (i_addr),
        .i_size       (i_size),
        .i_unsigned   (i_unsigned),
        .i_wrEnable   (i_wrEnable),
        .i_wrData     (i_wrData),
        .i_rdEnable   (i_rdEnable),
        .o_rdData     (o_rdData),
        .o_alignError (o_alignError),
        .bus          (bus.master)
    );

    DataMemory
    #(
        .MemWords (MemWords)
    )
    memory
    (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .bus     (bus.slave)
    );

    assign o_rangeError = bus.rangeError; // Only aligned accesses reach the memory

endmodule

/* sim/ClockGen.sv */
`timescale 1ns/10ps

module ClockGen
#(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 2
)
(
    output logic o_clk,
    output logic o_arstN
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PeriodNs / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_arstN = 1'b0;
        repeat (ResetCycles) @(posedge o_clk);
        @(negedge o_clk); // Release away from the active edge
        o_arstN = 1'b1;
    end

endmodule

/* sim/DataMemorySystemTb.sv */
`timescale 1ns/10ps

module DataMemorySystemTb;

    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 2;
    localparam int MemWords    = 256;
    localparam int NumRandom   = 16;
    localparam int IndexBits   = $clog2(MemWords);

    typedef logic [IndexBits-1:0] WordIndex;

    typedef struct packed
    {
        int                 lineNo;
        logic               isWrite;
        logic               isRead;
        CoreTypes::DataAddr addr;
        CoreTypes::DataSize size;
        logic               uns;
        CoreTypes::Data     wrData;
        CoreTypes::Data     expRdData;
        logic               expAlign;
        logic               expRange;
    } Entry;

    logic clk;
    logic arstN;
    logic wrEnable;
    logic rdEnable;
    logic uns;
    logic alignError;
    logic rangeError;
    logic loaded = 1'b0;
    int   errorCount = 0;
    int   checkCount = 0;

    CoreTypes::DataAddr addr;
    CoreTypes::DataSize size;
    CoreTypes::Data     wrData;
    CoreTypes::Data     rdData;
    CoreTypes::Data     refMem [MemWords]; // Model of the words the random block has written
    WordIndex           touched[$];
    Entry               entries[$];

    ClockGen #(.PeriodNs(ClockPeriod), .ResetCycles(ResetCycles)) clockGen
    (
        .o_clk   (clk),
        .o_arstN (arstN)
    );

    DataMemorySystem #(.MemWords(MemWords)) DUT
    (
        .i_clk        (clk),
        .i_arstN      (arstN),
        .i_addr       (addr),
        .i_size       (size),
        .i_unsigned   (uns),
        .i_wrEnable   (wrEnable),
        .i_wrData     (wrData),
        .i_rdEnable   (rdEnable),
        .o_rdData     (rdData),
        .o_alignError (alignError),
        .o_rangeError (rangeError)
    );

    task automatic checkValue(input string what, input CoreTypes::Data actual,
        input CoreTypes::Data expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic checkOutputs(input string tag, input CoreTypes::Data expRd,
        input logic expAlign, input logic expRange);
        checkValue({tag, " rdData"}, rdData, expRd);
        checkValue({tag, " alignError"}, {31'b0, alignError}, {31'b0, expAlign});
        checkValue({tag, " rangeError"}, {31'b0, rangeError}, {31'b0, expRange});
    endtask

    // Apply one access on a rising edge and return where the outputs are stable
    task automatic driveAccess(input logic wr, input logic rd, input CoreTypes::DataAddr a,
        input CoreTypes::DataSize s, input logic u, input CoreTypes::Data d);
        @(posedge clk);
        wrEnable <= wr;
        rdEnable <= rd;
        addr     <= a;
        size     <= s;
        uns      <= u;
        wrData   <= d;
        @(negedge clk);
    endtask

    task automatic loadEntries();
        int                 fd;
        int                 count;
        int                 lineNo;
        int                 sizeBits;
        string              line;
        logic [7:0]         opText;
        logic               u;
        logic               expAlign;
        logic               expRange;
        CoreTypes::DataAddr a;
        CoreTypes::Data     d;
        CoreTypes::Data     expRd;
        fd = $fopen("sim/access_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file sim/access_input.txt");
            errorCount++;
            return;
        end
        lineNo = 0;
        while (!$feof(fd))
        begin
            count = $fgets(line, fd);
            lineNo++;
            if (count <= 1 || line.getc(0) == "#")
                continue;
            count = $sscanf(line, "%s %h %d %d %h %h %d %d", opText, a, sizeBits, u, d,
                expRd, expAlign, expRange);
            if (count != 8 || !(opText inside {"R", "W", "I"}))
            begin
                $display("Stimulus line %0d could not be parsed", lineNo);
                errorCount++;
                continue;
            end
            entries.push_back(Entry'{lineNo, opText == "W", opText == "R", a,
                (sizeBits == 8) ? CoreTypes::DataSize_8 :
                (sizeBits == 16) ? CoreTypes::DataSize_16 : CoreTypes::DataSize_32,
                u, d, expRd, expAlign, expRange});
        end
        $fclose(fd);
    endtask

    task automatic runRandomBlock();
        WordIndex       idx;
        logic [1:0]     off;
        CoreTypes::Data value;
        CoreTypes::Data laneMask;
        for (int i = 0; i < NumRandom; i++)
        begin
            idx   = WordIndex'($urandom_range(MemWords - 1, 0));
            value = $urandom();
            driveAccess(1'b1, 1'b0, CoreTypes::DataAddr'({idx, 2'b00}), CoreTypes::DataSize_32,
                1'b0, value);
            checkOutputs($sformatf("random word write %0d", i), '0, 1'b0, 1'b0);
            refMem[idx] = value;
            touched.push_back(idx);
        end
        // Byte stores land in words that the loop above has already written
        for (int i = 0; i < NumRandom; i++)
        begin
            idx      = touched[$urandom_range(NumRandom - 1, 0)];
            off      = 2'($urandom_range(3, 0));
            value    = $urandom();
            laneMask = 32'hff00_0000 >> (8 * off);
            driveAccess(1'b1, 1'b0, CoreTypes::DataAddr'({idx, off}), CoreTypes::DataSize_8,
                1'b0, value);
            checkOutputs($sformatf("random byte write %0d", i), '0, 1'b0, 1'b0);
            refMem[idx] = (refMem[idx] & ~laneMask) | ({value[7:0], 24'b0} >> (8 * off));
        end
        foreach (touched[i])
        begin
            driveAccess(1'b0, 1'b1, CoreTypes::DataAddr'({touched[i], 2'b00}),
                CoreTypes::DataSize_32, 1'b0, '0);
            checkOutputs($sformatf("random read-back %0d", i), refMem[touched[i]], 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        wrEnable <= 1'b0;
        rdEnable <= 1'b0;
        addr     <= '0;
        size     <= CoreTypes::DataSize_32;
        uns      <= 1'b0;
        wrData   <= '0;
        void'($urandom(32'hc492));
        loadEntries();
        loaded = 1'b1;
        wait (arstN === 1'b1);
        foreach (entries[i])
        begin
            driveAccess(entries[i].isWrite, entries[i].isRead, entries[i].addr, entries[i].size,
                entries[i].uns, entries[i].wrData);
            checkOutputs($sformatf("input line %0d", entries[i].lineNo), entries[i].expRdData,
                entries[i].expAlign, entries[i].expRange);
        end
        runRandomBlock();
        driveAccess(1'b0, 1'b0, '0, CoreTypes::DataSize_32, 1'b0, '0);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial
    begin
        int cycles;
        wait (loaded);
        cycles = ResetCycles + entries.size() + 3 * NumRandom + 20;
        #(cycles * ClockPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* sim.f */
hw/CoreTypes.sv
hw/MemMap.sv
hw/DataMemoryBus.sv
hw/DataMemoryAdapter.sv
hw/DataMemory.sv
hw/DataMemorySystem.sv
sim/ClockGen.sv
sim/DataMemorySystemTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator, runs it and checks the log

TOP=DataMemorySystemTb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$(dirname "$0")" || { echo "Cannot enter the project directory"; exit 1; }

verilator --binary --timing --top-module "$TOP" -f sim.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

/* sim/access_input.txt */
# op(R read, W write, I idle) addr(hex) size(8/16/32) unsigned wrdata(hex) rddata(hex) align range
# Expected read data and error flags are for the cycle in which the line is applied
R 00000000 32 0 00000000 00000000 0 0
R 000003fc 32 0 00000000 00000000 0 0
W 00000010 32 0 12345678 00000000 0 0
R 00000010 32 0 00000000 12345678 0 0
W 000003fc 32 0 a5a5c3c3 00000000 0 0
W 00000020 8 0 000000aa 00000000 0 0
W 00000021 8 0 000000bb 00000000 0 0
W 00000022 8 0 000000cc 00000000 0 0
W 00000023 8 0 00000011 00000000 0 0
R 00000020 32 0 00000000 aabbcc11 0 0
R 00000020 8 0 00000000 ffffffaa 0 0
R 00000020 8 1 00000000 000000aa 0 0
R 00000021 8 0 00000000 ffffffbb 0 0
R 00000023 8 0 00000000 00000011 0 0
R 00000023 8 1 00000000 00000011 0 0
R 00000020 16 0 00000000 ffffaabb 0 0
R 00000020 16 1 00000000 0000aabb 0 0
R 00000022 16 0 00000000 ffffcc11 0 0
W 00000030 16 0 00001234 00000000 0 0
W 00000032 16 0 0000f00d 00000000 0 0
R 00000030 32 0 00000000 1234f00d 0 0
R 00000030 16 0 00000000 00001234 0 0
R 00000032 16 1 00000000 0000f00d 0 0
R 00000011 16 0 00000000 00000000 1 0
R 00000012 32 0 00000000 00000000 1 0
W 00000011 32 0 deadbeef 00000000 1 0
W 00000013 16 0 0000ffff 00000000 1 0
R 00000010 32 0 00000000 12345678 0 0
W 00000400 32 0 cafef00d 00000000 0 1
W 00000ffd 8 0 000000ff 00000000 0 1
R 00000400 32 0 00000000 00000000 0 1
R 00000000 32 0 00000000 00000000 0 0
R 000003fc 32 0 00000000 a5a5c3c3 0 0
W 00000402 32 0 11111111 00000000 1 0
I 00000400 32 0 00000000 00000000 0 0
I 00000011 16 0 00000000 00000000 0 0
